//--- verif/tsc_testdata.hex
// program at 000, data memory at 100, expected wwd words at 140, expected stores at 180.
// the wwd and store sections start with a count; each store is an address, then its data.
@000
// arithmetic, logic, shift and immediate group
6112 5534 F41C 42FD F81C F6C0 FC1C F6C1 FC1C FEC2 FC1C 4041 F4C3 FC1C F4C4 FC1C
F4C5 FC1C F8C6 FC1C F8C7 FC1C F4C7 FC1C
// loads with negative offsets, two stores, and a load of a stored word
72C4 F81C 73E1 FC1C 82D0 83FE 71D0 F41C
// every branch not taken and then taken; FC1C behind a taken branch is a marker
0601 F01C 0701 FC1C 1701 F41C 1601 FC1C 2401 F81C 2001 FC1C 3001 FC1C 3C02 FC1C
F41C 9040 FC1C
@040
// JAL to 050; the halt sequence at 042 is reached later by a backward BEQ
F01C A050 F81C F01D F01C 80D0
@050
F81C 411F F41A F41C 10ED FC1C
@060
F81C F819 FC1C
@100
C000 C101 C202 C303 C404 C505 C606 C707 C808 C909 CA0A CB0B CC0C CD0D CE0E CF0F
D010 D111 D212 D313 D414 D515 D616 D717 D818 D919 DA1A DB1B DC1C DD1D DE1E DF1F
E020 E121 E222 E323 E424 E525 E626 E727 E828 E929 EA2A EB2B EC2C ED2D EE2E EF2F
F030 F131 F232 F333 F434 F535 F636 F737 F838 F939 FA3A FB3B FC3C FD3D FE3E FF3F
@140
0017
1234 FFFD 1231 1237 1235 1275 EDCB EDCC
FFFA FFFE 091A C505 E222 C505 0041 C505
C505 E222 0041 0042 0053 0060 0053
@180
0002
0011 C505
003F E222

//--- verilog.f
+incdir+hw
hw/tsc_pkg.sv
hw/tsc_control.sv
hw/tsc_alu.sv
hw/tsc_regfile.sv
hw/tsc_core.sv
verif/tsc_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tsc_core_tb -f verilog.f -o tsc_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/tsc_core_sim)
sim_status=$?
printf '%s\n' "$sim_output"

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx "All tests passed"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1

//--- verif/tsc_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tsc_core_tb;

    import tsc_pkg::*;

    // layout of the testdata image, in words.
    localparam int IMAGE_SIZE   = 512;
    localparam int PROG_WORDS   = 256;
    localparam int DATA_BASE    = 'h100;
    localparam int DATA_WORDS   = 64;
    localparam int OUT_BASE     = 'h140;
    localparam int STORE_BASE   = 'h180;
    localparam int HALT_LIMIT   = 2000;
    localparam int QUIET_CYCLES = 20;

    logic  clk = 1'b0;
    logic  arst_n;
    word_t i_addr;
    word_t i_data;
    word_t d_addr;
    word_t d_wdata;
    logic  d_read;
    logic  d_write;
    word_t d_rdata;
    logic  wwd_valid;
    word_t wwd_data;
    logic  halted;

    word_t image [IMAGE_SIZE];
    word_t imem [PROG_WORDS];
    word_t dmem [DATA_WORDS];
    word_t exp_words [$];
    word_t exp_store_addr [$];
    word_t exp_store_data [$];
    int    exp_out_count;
    int    exp_store_count;
    int    out_seen;
    int    store_seen;
    int    cycles;

    tsc_core u_tsc_core (
        .clk       (clk),
        .arst_n    (arst_n),
        .i_addr    (i_addr),
        .i_data    (i_data),
        .d_addr    (d_addr),
        .d_wdata   (d_wdata),
        .d_read    (d_read),
        .d_write   (d_write),
        .d_rdata   (d_rdata),
        .wwd_valid (wwd_valid),
        .wwd_data  (wwd_data),
        .halted    (halted)
    );

    always #20 clk = ~clk;

    // both memories answer within the same cycle.
    assign i_data  = imem[i_addr[7:0]];
    assign d_rdata = dmem[d_addr[5:0]];

    always @(posedge clk) begin
        if (d_write) begin
            dmem[d_addr[5:0]] = d_wdata;
        end
    end

    task automatic stop_on_error();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("FAIL time=%0t %s expected %h actual %h", $time, name, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic check_store(input word_t exp_addr, input word_t exp_data,
                               input word_t act_addr, input word_t act_data);
        if (act_addr !== exp_addr) begin
            $display("FAIL time=%0t d_addr expected %h actual %h", $time, exp_addr, act_addr);
            stop_on_error();
        end else if (act_data !== exp_data) begin
            $display("FAIL time=%0t d_wdata expected %h actual %h", $time, exp_data, act_data);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAIL time=%0t %s expected %b actual %b", $time, name, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic load_image();
        for (int a = 0; a < IMAGE_SIZE; a++) begin
            image[a] = word_t'(a) ^ 16'hA5A5;
        end
        $readmemh("verif/tsc_testdata.hex", image);
        for (int a = 0; a < PROG_WORDS; a++) begin
            imem[a] = image[a];
        end
        for (int a = 0; a < DATA_WORDS; a++) begin
            dmem[a] = image[DATA_BASE + a];
        end
        exp_out_count   = int'(image[OUT_BASE]);
        exp_store_count = int'(image[STORE_BASE]);
        for (int k = 0; k < exp_out_count; k++) begin
            exp_words.push_back(image[OUT_BASE + 1 + k]);
        end
        for (int k = 0; k < exp_store_count; k++) begin
            exp_store_addr.push_back(image[STORE_BASE + 1 + 2 * k]);
            exp_store_data.push_back(image[STORE_BASE + 2 + 2 * k]);
        end
    endtask

    // outputs are sampled on the falling edge, half a cycle away from any update.
    always @(negedge clk) begin
        if (!arst_n) begin
            check_flag("wwd_valid", 1'b0, wwd_valid);
            check_flag("d_write", 1'b0, d_write);
            check_flag("d_read", 1'b0, d_read);
            check_flag("halted", 1'b0, halted);
        end else begin
            if (wwd_valid) begin
                if (exp_words.size() == 0) begin
                    $display("unexpected output word %h at time %0t", wwd_data, $time);
                    stop_on_error();
                end else begin
                    check_word("wwd_data", exp_words.pop_front(), wwd_data);
                    out_seen++;
                end
            end
            if (d_write) begin
                if (exp_store_addr.size() == 0) begin
                    $display("unexpected store to %h at time %0t", d_addr, $time);
                    stop_on_error();
                end else begin
                    check_store(exp_store_addr.pop_front(), exp_store_data.pop_front(),
                                d_addr, d_wdata);
                    store_seen++;
                end
            end
        end
    end

    initial begin
        arst_n     = 1'b0;
        out_seen   = 0;
        store_seen = 0;
        cycles     = 0;
        load_image();

        repeat (4) begin
            @(posedge clk);
        end
        #1 arst_n = 1'b1;

        @(negedge clk);
        check_word("i_addr", word_t'(0), i_addr);

        while (!halted && cycles < HALT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end

        if (!halted) begin
            $display("the core never halted within %0d cycles", HALT_LIMIT);
            stop_on_error();
        end else begin
            repeat (QUIET_CYCLES) begin
                @(negedge clk);
                check_flag("halted", 1'b1, halted);
                check_flag("wwd_valid", 1'b0, wwd_valid);
                check_flag("d_write", 1'b0, d_write);
                check_flag("d_read", 1'b0, d_read);
            end
            check_word("output word count", word_t'(exp_out_count), word_t'(out_seen));
            check_word("store count", word_t'(exp_store_count), word_t'(store_seen));
            $display("All tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- hw/tsc_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "tsc_config.svh"

module tsc_core (
    input  logic           clk,
    input  logic           arst_n,
    output tsc_pkg::word_t i_addr,
    input  tsc_pkg::word_t i_data,
    output tsc_pkg::word_t d_addr,
    output tsc_pkg::word_t d_wdata,
    output logic           d_read,
    output logic           d_write,
    input  tsc_pkg::word_t d_rdata,
    output logic           wwd_valid,
    output tsc_pkg::word_t wwd_data,
    output logic           halted
);

    import tsc_pkg::*;

    word_t      pc;
    word_t      next_pc;
    word_t      fetch_pc_inc;
    word_t      held_pc;
    word_t      link_pc;
    instr_u     held_instr;
    logic       held_valid;
    ctrl_t      ctrl;
    word_t      rs_data;
    word_t      rt_data;
    word_t      alu_result;
    word_t      wb_data;
    word_t      imm_sext;
    word_t      branch_target;
    word_t      jump_target;
    logic [1:0] wr_addr;
    logic       branch_cond;
    logic       branch_taken;
    logic       redirect;
    logic       stop;

    tsc_control u_tsc_control (
        .instr (held_instr),
        .flush (!held_valid),
        .ctrl  (ctrl)
    );

    tsc_regfile u_tsc_regfile (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs_addr (held_instr.i.rs),
        .rt_addr (held_instr.i.rt),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wr_en   (ctrl.reg_write),
        .wr_addr (wr_addr),
        .wr_data (wb_data)
    );

    tsc_alu u_tsc_alu (
        .op     (ctrl.alu_op),
        .src    (ctrl.alu_src),
        .a      (rs_data),
        .b_reg  (rt_data),
        .imm    (held_instr.i.imm),
        .result (alu_result)
    );

    assign fetch_pc_inc  = pc + word_t'(1);
    assign link_pc       = held_pc + word_t'(1);
    assign imm_sext      = {{(`TSC_WORD_SIZE-8){held_instr.i.imm[7]}}, held_instr.i.imm};
    assign branch_target = link_pc + imm_sext;
    assign jump_target   = {held_pc[`TSC_WORD_SIZE-1 -: 4], held_instr.j.target};

    always_comb begin
        case (held_instr.i.opcode)
            BNE_OP:  branch_cond = (rs_data != rt_data);
            BEQ_OP:  branch_cond = (rs_data == rt_data);
            BGZ_OP:  branch_cond = ($signed(rs_data) > 0);
            BLZ_OP:  branch_cond = ($signed(rs_data) < 0);
            default: branch_cond = 1'b0;
        endcase
    end

    assign branch_taken = ctrl.branch && branch_cond;
    assign redirect     = branch_taken || ctrl.jtype_jump || ctrl.rtype_jump;
    // a halt in execute already freezes fetch so nothing behind it runs.
    assign stop         = halted || ctrl.is_halted;

    always_comb begin
        if (stop) begin
            next_pc = pc;
        end else if (ctrl.rtype_jump) begin
            next_pc = rs_data;
        end else if (ctrl.jtype_jump) begin
            next_pc = jump_target;
        end else if (branch_taken) begin
            next_pc = branch_target;
        end else begin
            next_pc = fetch_pc_inc;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc         <= word_t'(`TSC_RESET_PC);
            held_valid <= 1'b0;
            halted     <= 1'b0;
        end else begin
            pc         <= next_pc;
            held_valid <= !redirect && !stop;
            if (ctrl.is_halted) begin
                halted <= 1'b1;
            end
        end
    end

    // the held word is qualified by held_valid alone.
    always_ff @(posedge clk) begin
        held_instr <= i_data;
        held_pc    <= pc;
    end

    always_comb begin
        case (ctrl.reg_dest)
            DEST_RT: wr_addr = held_instr.i.rt;
            DEST_R2: wr_addr = 2'd2;
            default: wr_addr = held_instr.r.rd;
        endcase
    end

    always_comb begin
        if (ctrl.mem_to_reg) begin
            wb_data = d_rdata;
        end else if (ctrl.reg_dest == DEST_R2) begin
            wb_data = link_pc;
        end else begin
            wb_data = alu_result;
        end
    end

    assign i_addr = pc;

    // the ALU adds the offset to rs for loads and stores.
    assign d_addr  = alu_result;
    assign d_wdata = rt_data;
    assign d_read  = ctrl.mem_read;
    assign d_write = ctrl.mem_write;

    assign wwd_valid = ctrl.is_wwd;
    assign wwd_data  = rs_data;

endmodule

`default_nettype wire

//--- hw/tsc_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "tsc_config.svh"

module tsc_regfile (
    input  logic           clk,
    input  logic           arst_n,
    input  logic [1:0]     rs_addr,
    input  logic [1:0]     rt_addr,
    output tsc_pkg::word_t rs_data,
    output tsc_pkg::word_t rt_data,
    input  logic           wr_en,
    input  logic [1:0]     wr_addr,
    input  tsc_pkg::word_t wr_data
);

    import tsc_pkg::*;

    word_t regs [`TSC_NUM_REGS];

    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `TSC_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

//--- hw/tsc_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "tsc_config.svh"

module tsc_alu (
    input  tsc_pkg::alu_func_e op,
    input  logic [1:0]         src,
    input  tsc_pkg::word_t     a,
    input  tsc_pkg::word_t     b_reg,
    input  logic [7:0]         imm,
    output tsc_pkg::word_t     result
);

    import tsc_pkg::*;

    word_t op_a;
    word_t op_b;

    // LHI shifts the zero-extended immediate up by eight.
    assign op_a = (src == SRC_LHI) ? word_t'(imm) : a;

    always_comb begin
        case (src)
            SRC_IMM: op_b = {{(`TSC_WORD_SIZE-8){imm[7]}}, imm};
            SRC_ONE: op_b = word_t'(1);
            SRC_LHI: op_b = word_t'(8);
            default: op_b = b_reg;
        endcase
    end

    always_comb begin
        case (op)
            ALU_ADD: result = op_a + op_b;
            ALU_SUB: result = op_a - op_b;
            ALU_AND: result = op_a & op_b;
            ALU_ORR: result = op_a | op_b;
            ALU_NOT: result = ~op_a;
            ALU_TCP: result = ~op_a + word_t'(1);
            ALU_SHL: result = op_a << op_b;
            // right shift keeps the sign.
            ALU_SHR: result = word_t'($signed(op_a) >>> op_b);
            default: result = op_a + op_b;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/tsc_control.sv
`timescale 1ns/1ps
`default_nettype none

module tsc_control (
    input  tsc_pkg::instr_u instr,
    input  logic            flush,
    output tsc_pkg::ctrl_t  ctrl
);

    import tsc_pkg::*;

    tsc_opcode_e opcode;
    tsc_func_e   func;
    logic        rtype;
    logic        itype;
    logic        jtype;
    logic        load;
    logic        store;
    logic        alu_func;
    logic        shift_func;

    assign opcode = instr.r.opcode;
    assign func   = instr.r.func;

    assign rtype = (opcode == ALU_OP);
    // branches, immediate arithmetic and both memory operations use the I view.
    assign itype = opcode inside {BNE_OP, BEQ_OP, BGZ_OP, BLZ_OP, ADI_OP, ORI_OP,
                                  LHI_OP, LWD_OP, SWD_OP};
    assign load  = (opcode == LWD_OP);
    assign store = (opcode == SWD_OP);
    assign jtype = (opcode == JMP_OP) || (opcode == JAL_OP);

    assign alu_func   = rtype && (func inside {TSC_ADD_FUNC, TSC_SUB_FUNC, TSC_AND_FUNC,
                                               TSC_ORR_FUNC, TSC_NOT_FUNC, TSC_TCP_FUNC,
                                               TSC_SHL_FUNC, TSC_SHR_FUNC});
    assign shift_func = rtype && (func inside {TSC_SHL_FUNC, TSC_SHR_FUNC});

    always_comb begin
        ctrl = '0;
        if (!flush) begin
            ctrl.mem_read   = load;
            ctrl.mem_to_reg = load;
            ctrl.mem_write  = store;
            ctrl.is_halted  = rtype && (func == TSC_HLT_FUNC);
            ctrl.is_wwd     = rtype && (func == TSC_WWD_FUNC);
            ctrl.jtype_jump = jtype;
            ctrl.rtype_jump = rtype && (func inside {TSC_JPR_FUNC, TSC_JRL_FUNC});
            ctrl.branch     = opcode inside {BNE_OP, BEQ_OP, BGZ_OP, BLZ_OP};

            ctrl.reg_write = alu_func
                          || (rtype && (func == TSC_JRL_FUNC))
                          || (opcode inside {ADI_OP, ORI_OP, LHI_OP, LWD_OP})
                          || (opcode == JAL_OP);

            if (shift_func) begin
                ctrl.alu_src = SRC_ONE;
            end else if (opcode == LHI_OP) begin
                ctrl.alu_src = SRC_LHI;
            end else if (itype) begin
                ctrl.alu_src = SRC_IMM;
            end else begin
                ctrl.alu_src = SRC_REG;
            end

            // both link instructions return through register two.
            if ((opcode == JAL_OP) || (rtype && (func == TSC_JRL_FUNC))) begin
                ctrl.reg_dest = DEST_R2;
            end else if (itype) begin
                ctrl.reg_dest = DEST_RT;
            end else begin
                ctrl.reg_dest = DEST_RD;
            end

            case (opcode)
                ADI_OP:  ctrl.alu_op = ALU_ADD;
                ORI_OP:  ctrl.alu_op = ALU_ORR;
                LHI_OP:  ctrl.alu_op = ALU_SHL;
                ALU_OP: begin
                    case (func)
                        TSC_SUB_FUNC: ctrl.alu_op = ALU_SUB;
                        TSC_AND_FUNC: ctrl.alu_op = ALU_AND;
                        TSC_ORR_FUNC: ctrl.alu_op = ALU_ORR;
                        TSC_NOT_FUNC: ctrl.alu_op = ALU_NOT;
                        TSC_TCP_FUNC: ctrl.alu_op = ALU_TCP;
                        TSC_SHL_FUNC: ctrl.alu_op = ALU_SHL;
                        TSC_SHR_FUNC: ctrl.alu_op = ALU_SHR;
                        default:      ctrl.alu_op = ALU_ADD;
                    endcase
                end
                // loads and stores add the offset to rs for the address.
                default: ctrl.alu_op = ALU_ADD;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/tsc_pkg.sv
`default_nettype none

`include "tsc_config.svh"

package tsc_pkg;

    typedef logic [`TSC_WORD_SIZE-1:0] word_t;

    typedef enum logic [3:0] {
        BNE_OP = 4'd0,
        BEQ_OP = 4'd1,
        BGZ_OP = 4'd2,
        BLZ_OP = 4'd3,
        ADI_OP = 4'd4,
        ORI_OP = 4'd5,
        LHI_OP = 4'd6,
        LWD_OP = 4'd7,
        SWD_OP = 4'd8,
        JMP_OP = 4'd9,
        JAL_OP = 4'd10,
        ALU_OP = 4'd15
    } tsc_opcode_e;

    // function field of the R-type word.
    typedef enum logic [5:0] {
        TSC_ADD_FUNC = 6'd0,
        TSC_SUB_FUNC = 6'd1,
        TSC_AND_FUNC = 6'd2,
        TSC_ORR_FUNC = 6'd3,
        TSC_NOT_FUNC = 6'd4,
        TSC_TCP_FUNC = 6'd5,
        TSC_SHL_FUNC = 6'd6,
        TSC_SHR_FUNC = 6'd7,
        TSC_JPR_FUNC = 6'd25,
        TSC_JRL_FUNC = 6'd26,
        TSC_WWD_FUNC = 6'd28,
        TSC_HLT_FUNC = 6'd29
    } tsc_func_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_ORR = 3'd3,
        ALU_NOT = 3'd4,
        ALU_TCP = 3'd5,
        ALU_SHL = 3'd6,
        ALU_SHR = 3'd7
    } alu_func_e;

    // operand B sources of the ALU.
    localparam logic [1:0] SRC_REG = 2'b00;
    localparam logic [1:0] SRC_IMM = 2'b01;
    localparam logic [1:0] SRC_ONE = 2'b10;
    localparam logic [1:0] SRC_LHI = 2'b11;

    // writeback destinations.
    localparam logic [1:0] DEST_RD = 2'b00;
    localparam logic [1:0] DEST_RT = 2'b01;
    localparam logic [1:0] DEST_R2 = 2'b10;

    typedef struct packed {
        tsc_opcode_e opcode;
        logic [1:0]  rs;
        logic [1:0]  rt;
        logic [1:0]  rd;
        tsc_func_e   func;
    } r_instr_t;

    typedef struct packed {
        tsc_opcode_e opcode;
        logic [1:0]  rs;
        logic [1:0]  rt;
        logic [7:0]  imm;
    } i_instr_t;

    typedef struct packed {
        tsc_opcode_e opcode;
        logic [11:0] target;
    } j_instr_t;

    // all three views share the opcode in the top nibble.
    typedef union packed {
        r_instr_t r;
        i_instr_t i;
        j_instr_t j;
    } instr_u;

    typedef struct packed {
        logic [1:0] alu_src;
        alu_func_e  alu_op;
        logic [1:0] reg_dest;
        logic       mem_write;
        logic       mem_read;
        logic       reg_write;
        logic       mem_to_reg;
        logic       is_halted;
        logic       is_wwd;
        logic       jtype_jump;
        logic       rtype_jump;
        logic       branch;
    } ctrl_t;

endpackage

`default_nettype wire

//--- hw/tsc_config.svh
`ifndef TSC_CONFIG_SVH
`define TSC_CONFIG_SVH

// data and address width of the core.
`define TSC_WORD_SIZE 16

// the instruction set names exactly four general registers.
`define TSC_NUM_REGS 4

// first fetch address after reset is released.
`define TSC_RESET_PC 'h0

`endif
